// File: source/mem_bridge_pkg.sv
`default_nettype none

package mem_bridge_pkg;

	// Controller command opcodes, 3 bits on the port
	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} mem_cmd_t;

	// Bridge sequencer states
	typedef enum logic [3:0] {
		ST_IDLE,
		// Write burst: pop a host word, send both halves, then the command
		ST_WR_POP,
		ST_WR_LO,
		ST_WR_HI,
		ST_WR_CMD,
		// Read burst: command, then pair beats into host words
		ST_RD_CMD,
		ST_RD_LO,
		ST_RD_HI,
		ST_RD_PUSH
	} bridge_state_t;

endpackage

`default_nettype wire

// File: source/word_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module word_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 64
) (
	input  wire                          clk,
	input  wire                          reset_d,
	input  wire                          push,
	input  wire  [WIDTH-1:0]             push_data,
	output logic                         full,
	input  wire                          pop,
	output logic [WIDTH-1:0]             pop_data,
	output logic                         pop_valid,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Storage and read register
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (reset_d) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			// Explicit wrap so DEPTH need not be a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/burst_bridge.sv
`default_nettype none
`timescale 1ns/1ns

module burst_bridge import mem_bridge_pkg::*; #(
	parameter int BURST_LEN = 32,
	parameter int BUF_DEPTH = 64
) (
	input  wire                              clk,
	input  wire                              reset_d,
	input  wire                              writes_en,
	input  wire                              reads_en,
	input  wire                              calib_done,
	// Input buffer read side
	output logic                             ib_pop,
	input  wire  [63:0]                      ib_data,
	input  wire                              ib_valid,
	input  wire  [$clog2(BUF_DEPTH+1)-1:0]   ib_count,
	// Output buffer write side
	output logic                             ob_push,
	output logic [63:0]                      ob_data,
	input  wire  [$clog2(BUF_DEPTH+1)-1:0]   ob_count,
	// Controller user port
	input  wire                              cmd_full,
	output logic                             cmd_en,
	output mem_cmd_t                         cmd_instr,
	output logic [29:0]                      cmd_byte_addr,
	input  wire                              wr_full,
	output logic                             wr_en,
	output logic [31:0]                      wr_data,
	input  wire                              rd_empty,
	output logic                             rd_en,
	input  wire  [31:0]                      rd_data
);

	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam int BC_W  = $clog2(BURST_LEN + 1);
	// Queued reads are counted in 32-bit beats
	localparam int Q_W   = $clog2(2 * BUF_DEPTH + BURST_LEN + 1);
	localparam int U_W   = Q_W + 1;

	bridge_state_t    state;
	logic [BC_W-1:0]  burst_cnt;
	logic [29:0]      wr_addr;
	logic [29:0]      rd_addr;
	logic [Q_W-1:0]   reads_queued;
	logic [U_W-1:0]   ob_used;
	logic             have_word;
	logic [63:0]      word_reg;
	logic [31:0]      rd_lo;
	logic             cmd_taken;
	logic             wr_go;
	logic             rd_go;

	// Port outputs decoded from the state
	assign ib_pop    = (state == ST_WR_POP);
	assign wr_en     = ((state == ST_WR_LO && have_word) || state == ST_WR_HI) && !wr_full;
	assign wr_data   = (state == ST_WR_HI) ? word_reg[63:32] : word_reg[31:0];
	assign cmd_en    = (state == ST_WR_CMD) || (state == ST_RD_CMD);
	assign cmd_taken = cmd_en && !cmd_full;
	assign rd_en     = (state == ST_RD_LO || state == ST_RD_HI) && !rd_empty;
	assign ob_push   = (state == ST_RD_PUSH);
	assign ob_data   = {rd_data, rd_lo};

	always_comb begin
		cmd_instr     = (state == ST_RD_CMD) ? CMD_READ : CMD_WRITE;
		cmd_byte_addr = (state == ST_RD_CMD) ? rd_addr : wr_addr;
	end

	// Words already in the output buffer plus words still in flight
	assign ob_used = U_W'(ob_count) + U_W'(reads_queued >> 1) + U_W'(BURST_LEN / 2);

	assign wr_go = calib_done && writes_en && (ib_count >= CNT_W'(BURST_LEN / 2));
	// Only read back what has already been written
	assign rd_go = calib_done && reads_en && (rd_addr != wr_addr)
		&& (ob_used <= U_W'(BUF_DEPTH));

	always_ff @(posedge clk) begin
		if (ib_valid)
			word_reg <= ib_data;
		// rd_data holds until the next rd_en, so a stall recaptures the same beat
		if (state == ST_RD_HI)
			rd_lo <= rd_data;
	end

	always_ff @(posedge clk) begin
		if (reset_d) begin
			state        <= ST_IDLE;
			burst_cnt    <= '0;
			wr_addr      <= '0;
			rd_addr      <= '0;
			reads_queued <= '0;
			have_word    <= 1'b0;
		end else begin
			if (ib_pop)
				have_word <= 1'b0;
			else if (ib_valid)
				have_word <= 1'b1;

			if (cmd_taken && state == ST_RD_CMD)
				reads_queued <= reads_queued + Q_W'(BURST_LEN);
			else if (ob_push)
				reads_queued <= reads_queued - Q_W'(2);

			case (state)
				ST_IDLE: begin
					burst_cnt <= BC_W'(BURST_LEN);
					// Writes take priority over reads
					if (wr_go)
						state <= ST_WR_POP;
					else if (rd_go)
						state <= ST_RD_CMD;
				end
				ST_WR_POP: state <= ST_WR_LO;
				ST_WR_LO: begin
					if (have_word && !wr_full)
						state <= ST_WR_HI;
				end
				ST_WR_HI: begin
					if (!wr_full) begin
						burst_cnt <= burst_cnt - BC_W'(2);
						state <= (burst_cnt == BC_W'(2)) ? ST_WR_CMD : ST_WR_POP;
					end
				end
				ST_WR_CMD: begin
					if (!cmd_full) begin
						wr_addr <= wr_addr + 30'(4 * BURST_LEN);
						state   <= ST_IDLE;
					end
				end
				ST_RD_CMD: begin
					if (!cmd_full) begin
						rd_addr <= rd_addr + 30'(4 * BURST_LEN);
						state   <= ST_RD_LO;
					end
				end
				ST_RD_LO: begin
					if (!rd_empty)
						state <= ST_RD_HI;
				end
				ST_RD_HI: begin
					if (!rd_empty)
						state <= ST_RD_PUSH;
				end
				ST_RD_PUSH: begin
					burst_cnt <= burst_cnt - BC_W'(2);
					state <= (burst_cnt == BC_W'(2)) ? ST_IDLE : ST_RD_LO;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/port_mem_model.sv
`default_nettype none
`timescale 1ns/1ns

module port_mem_model import mem_bridge_pkg::*; #(
	parameter int BURST_LEN    = 32,
	parameter int MEM_WORDS    = 1024,
	parameter int CALIB_CYCLES = 20,
	parameter int RD_LATENCY   = 6
) (
	input  wire          clk,
	input  wire          reset_d,
	output logic         calib_done,
	input  wire          cmd_en,
	input  wire mem_cmd_t cmd_instr,
	input  wire  [29:0]  cmd_byte_addr,
	output logic         cmd_full,
	input  wire          wr_en,
	input  wire  [31:0]  wr_data,
	output logic         wr_full,
	input  wire          rd_en,
	output logic [31:0]  rd_data,
	output logic         rd_empty
);

	localparam int ADDR_W   = $clog2(MEM_WORDS);
	localparam int BC_W     = $clog2(BURST_LEN + 1);
	localparam int LW       = $clog2(RD_LATENCY + 1);
	localparam int CW       = $clog2(CALIB_CYCLES + 1);
	localparam int RF_DEPTH = 64;

	typedef enum logic [1:0] {ENG_IDLE, ENG_WRITE, ENG_WAIT, ENG_READ} eng_state_t;

	logic [31:0]       ram [MEM_WORDS];
	logic [CW-1:0]     calib_cnt;
	// Four-entry command queue
	mem_cmd_t          cq_instr [4];
	logic [ADDR_W-1:0] cq_addr [4];
	logic [1:0]        cq_wr, cq_rd;
	logic [2:0]        cq_count;
	// Write and read data FIFOs of 64 beats
	logic [31:0]       wf_mem [RF_DEPTH];
	logic [5:0]        wf_wr, wf_rd;
	logic [6:0]        wf_count;
	logic [31:0]       rf_mem [RF_DEPTH];
	logic [5:0]        rf_wr, rf_rd;
	logic [6:0]        rf_count;
	// Beats promised to accepted reads but not yet popped
	logic [7:0]        rd_reserved;
	eng_state_t        eng_state;
	logic [ADDR_W-1:0] eng_addr;
	logic [BC_W-1:0]   beat_cnt;
	logic [LW-1:0]     lat_cnt;
	logic cq_push, cq_pop, wf_push, wf_pop, rf_push, rf_pop, rd_accept;

	assign cmd_full  = (cq_count == 3'd4) || ((cmd_instr == CMD_READ)
		&& (({1'b0, rd_reserved} + 9'(BURST_LEN)) > 9'(RF_DEPTH)));
	assign cq_push   = cmd_en && !cmd_full;
	assign cq_pop    = (eng_state == ENG_IDLE) && (cq_count != 3'd0);
	assign rd_accept = cq_push && (cmd_instr == CMD_READ);
	assign wr_full   = (wf_count == 7'(RF_DEPTH));
	assign wf_push   = wr_en && !wr_full;
	assign wf_pop    = (eng_state == ENG_WRITE) && (wf_count != 7'd0);
	assign rd_empty  = (rf_count == 7'd0);
	assign rf_push   = (eng_state == ENG_READ);
	assign rf_pop    = rd_en && !rd_empty;

	always_ff @(posedge clk) begin
		if (reset_d) begin
			calib_cnt  <= '0;
			calib_done <= 1'b0;
		end else if (!calib_done) begin
			calib_cnt <= calib_cnt + 1'b1;
			if (calib_cnt == CW'(CALIB_CYCLES - 1))
				calib_done <= 1'b1;
		end
	end

	// Queue, FIFO and RAM storage
	always_ff @(posedge clk) begin
		if (cq_push) begin
			cq_instr[cq_wr] <= cmd_instr;
			cq_addr[cq_wr]  <= cmd_byte_addr[ADDR_W+1:2];
		end
		if (wf_push)
			wf_mem[wf_wr] <= wr_data;
		if (wf_pop)
			ram[eng_addr] <= wf_mem[wf_rd];
		if (rf_push)
			rf_mem[rf_wr] <= ram[eng_addr];
		if (rf_pop)
			rd_data <= rf_mem[rf_rd];
	end

	always_ff @(posedge clk) begin
		if (reset_d) begin
			cq_wr       <= '0;
			cq_rd       <= '0;
			cq_count    <= '0;
			wf_wr       <= '0;
			wf_rd       <= '0;
			wf_count    <= '0;
			rf_wr       <= '0;
			rf_rd       <= '0;
			rf_count    <= '0;
			rd_reserved <= '0;
		end else begin
			cq_wr <= cq_wr + 2'(cq_push);
			cq_rd <= cq_rd + 2'(cq_pop);
			cq_count <= cq_count + 3'(cq_push) - 3'(cq_pop);
			wf_wr <= wf_wr + 6'(wf_push);
			wf_rd <= wf_rd + 6'(wf_pop);
			wf_count <= wf_count + 7'(wf_push) - 7'(wf_pop);
			rf_wr <= rf_wr + 6'(rf_push);
			rf_rd <= rf_rd + 6'(rf_pop);
			rf_count <= rf_count + 7'(rf_push) - 7'(rf_pop);
			rd_reserved <= rd_reserved + (rd_accept ? 8'(BURST_LEN) : 8'd0) - 8'(rf_pop);
		end
	end

	// Command engine works through the queue one command at a time
	always_ff @(posedge clk) begin
		if (reset_d) begin
			eng_state <= ENG_IDLE;
			eng_addr  <= '0;
			beat_cnt  <= '0;
			lat_cnt   <= '0;
		end else begin
			case (eng_state)
				ENG_IDLE: begin
					if (cq_pop) begin
						eng_addr  <= cq_addr[cq_rd];
						beat_cnt  <= BC_W'(BURST_LEN);
						// Two cycles go to queueing and dispatch
						lat_cnt   <= LW'(RD_LATENCY - 3);
						eng_state <= (cq_instr[cq_rd] == CMD_WRITE) ? ENG_WRITE : ENG_WAIT;
					end
				end
				ENG_WAIT: begin
					lat_cnt <= lat_cnt - 1'b1;
					if (lat_cnt == '0)
						eng_state <= ENG_READ;
				end
				ENG_WRITE, ENG_READ: begin
					if (wf_pop || rf_push) begin
						eng_addr <= eng_addr + 1'b1;
						beat_cnt <= beat_cnt - 1'b1;
						if (beat_cnt == BC_W'(1))
							eng_state <= ENG_IDLE;
					end
				end
				default: eng_state <= ENG_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/bridge_top.sv
`default_nettype none
`timescale 1ns/1ns

module bridge_top #(
	parameter int BURST_LEN    = 32,
	parameter int BUF_DEPTH    = 64,
	parameter int MEM_WORDS    = 1024,
	parameter int CALIB_CYCLES = 20,
	parameter int RD_LATENCY   = 6
) (
	input  wire          clk,
	input  wire          reset_d,
	input  wire          writes_en,
	input  wire          reads_en,
	output logic         calib_done,
	input  wire          in_push,
	input  wire  [63:0]  in_data,
	output logic         in_full,
	input  wire          out_pop,
	output logic [63:0]  out_data,
	output logic         out_valid,
	output logic         out_empty
);

	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	logic              ib_pop, ib_valid;
	logic [63:0]       ib_data;
	logic [CNT_W-1:0]  ib_count;
	logic              ob_push;
	logic [63:0]       ob_data;
	logic [CNT_W-1:0]  ob_count;
	logic              cmd_en, cmd_full;
	mem_bridge_pkg::mem_cmd_t cmd_instr;
	logic [29:0]       cmd_byte_addr;
	logic              wr_en, wr_full, rd_en, rd_empty;
	logic [31:0]       wr_data, rd_data;

	// Host words waiting to be written
	word_fifo #(.WIDTH(64), .DEPTH(BUF_DEPTH)) u_in_buf (
		.clk(clk), .reset_d(reset_d),
		.push(in_push), .push_data(in_data), .full(in_full),
		.pop(ib_pop), .pop_data(ib_data), .pop_valid(ib_valid),
		.empty(), .count(ib_count)
	);

	burst_bridge #(.BURST_LEN(BURST_LEN), .BUF_DEPTH(BUF_DEPTH)) u_bridge (
		.clk(clk), .reset_d(reset_d), .writes_en(writes_en), .reads_en(reads_en),
		.calib_done(calib_done),
		.ib_pop(ib_pop), .ib_data(ib_data), .ib_valid(ib_valid), .ib_count(ib_count),
		.ob_push(ob_push), .ob_data(ob_data), .ob_count(ob_count),
		.cmd_full(cmd_full), .cmd_en(cmd_en), .cmd_instr(cmd_instr),
		.cmd_byte_addr(cmd_byte_addr), .wr_full(wr_full), .wr_en(wr_en),
		.wr_data(wr_data), .rd_empty(rd_empty), .rd_en(rd_en), .rd_data(rd_data)
	);

	// Read-back words for the host, never overfilled by the bridge
	word_fifo #(.WIDTH(64), .DEPTH(BUF_DEPTH)) u_out_buf (
		.clk(clk), .reset_d(reset_d),
		.push(ob_push), .push_data(ob_data), .full(),
		.pop(out_pop), .pop_data(out_data), .pop_valid(out_valid),
		.empty(out_empty), .count(ob_count)
	);

	port_mem_model #(
		.BURST_LEN(BURST_LEN), .MEM_WORDS(MEM_WORDS),
		.CALIB_CYCLES(CALIB_CYCLES), .RD_LATENCY(RD_LATENCY)
	) u_mem (
		.clk(clk), .reset_d(reset_d), .calib_done(calib_done),
		.cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_byte_addr(cmd_byte_addr),
		.cmd_full(cmd_full), .wr_en(wr_en), .wr_data(wr_data), .wr_full(wr_full),
		.rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty)
	);

endmodule

`default_nettype wire

// File: verif/bridge_checker.sv
`default_nettype none
`timescale 1ns/1ns

module bridge_checker #(
	parameter int BURST_LEN = 32,
	parameter int BUF_DEPTH = 64
) (
	input wire                                        clk,
	input wire                                        reset_d,
	input wire                                        calib_done,
	input wire                                        cmd_en,
	input wire                                        wr_en,
	input wire                                        wr_full,
	input wire                                        ob_push,
	input wire [$clog2(BUF_DEPTH+1)-1:0]              ob_count,
	input wire [$clog2(2*BUF_DEPTH+BURST_LEN+1)-1:0]  reads_queued
);

	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam int Q_W   = $clog2(2 * BUF_DEPTH + BURST_LEN + 1);

	// The controller accepts nothing before calibration
	a_cmd_after_calib: assert property (@(posedge clk) disable iff (reset_d)
		cmd_en |-> calib_done)
		else $error("command issued before calib_done");

	a_wr_not_full: assert property (@(posedge clk) disable iff (reset_d)
		wr_en |-> !wr_full)
		else $error("write beat while the write FIFO is full");

	a_ob_room: assert property (@(posedge clk) disable iff (reset_d)
		ob_push |-> (ob_count != CNT_W'(BUF_DEPTH)))
		else $error("push into a full output buffer");

	// Each pushed word must have been requested by a read command
	a_queue_no_underflow: assert property (@(posedge clk) disable iff (reset_d)
		ob_push |-> (reads_queued >= Q_W'(2)))
		else $error("queued read count underflow");

endmodule

bind burst_bridge bridge_checker #(.BURST_LEN(BURST_LEN), .BUF_DEPTH(BUF_DEPTH)) u_checker (
	.clk(clk), .reset_d(reset_d), .calib_done(calib_done), .cmd_en(cmd_en),
	.wr_en(wr_en), .wr_full(wr_full), .ob_push(ob_push),
	.ob_count(ob_count), .reads_queued(reads_queued)
);

`default_nettype wire

// File: verif/bridge_tb.sv
`default_nettype none
`timescale 1ns/1ns

module bridge_tb;

	localparam int BURST_LEN    = 32;
	localparam int BUF_DEPTH    = 64;
	localparam int MEM_WORDS    = 1024;
	localparam int CALIB_CYCLES = 20;
	localparam int RD_LATENCY   = 6;
	// Words pushed before the partial burst check
	localparam int PART_WORDS   = 5;

	logic        clk;
	logic        reset_d;
	logic        writes_en;
	logic        reads_en;
	logic        calib_done;
	logic        in_push;
	logic [63:0] in_data;
	logic        in_full;
	logic        out_pop;
	logic [63:0] out_data;
	logic        out_valid;
	logic        out_empty;

	logic [63:0] words [$];
	int          word_count;
	int          rx_idx;
	int          cycle_cnt;
	int          cycle_limit;
	logic [31:0] lfsr;
	logic        pop_random;
	logic        calib_seen;

	bridge_top #(
		.BURST_LEN(BURST_LEN), .BUF_DEPTH(BUF_DEPTH), .MEM_WORDS(MEM_WORDS),
		.CALIB_CYCLES(CALIB_CYCLES), .RD_LATENCY(RD_LATENCY)
	) uut (
		.clk(clk), .reset_d(reset_d), .writes_en(writes_en), .reads_en(reads_en),
		.calib_done(calib_done), .in_push(in_push), .in_data(in_data), .in_full(in_full),
		.out_pop(out_pop), .out_data(out_data), .out_valid(out_valid), .out_empty(out_empty)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			report_failure();
		end
	end

	task automatic report_failure();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_word(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			report_failure();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			report_failure();
		end
	endtask

	// Galois form, one step per bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h80200003;
		return n;
	endfunction

	// Wait for the next edge, collect output words and drive out_pop
	task automatic step_cycle();
		@(posedge clk);
		#1;
		if (calib_seen)
			check_flag(calib_done, 1'b1, "calib_done");
		if (out_valid) begin
			if (rx_idx >= word_count) begin
				$display("FAILED at %0t ns: extra output word %h", $time, out_data);
				report_failure();
			end else begin
				check_word(out_data, words[rx_idx], $sformatf("output word %0d", rx_idx));
				rx_idx++;
			end
		end
		out_pop = 1'b0;
		if (pop_random) begin
			lfsr = lfsr_step(lfsr);
			out_pop = lfsr[0];
		end
	endtask

	task automatic push_word(input logic [63:0] w);
		while (in_full)
			step_cycle();
		in_push = 1'b1;
		in_data = w;
		step_cycle();
		in_push = 1'b0;
	endtask

	// Comment lines start with #, then the word count, then one word per line
	task automatic load_words();
		int fd;
		int code;
		string line;
		logic [63:0] value;
		fd = $fopen("verif/bridge_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verif/bridge_input.txt");
			report_failure();
		end
		word_count = -1;
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) != "#") begin
				if (word_count < 0) begin
					code = $sscanf(line, "%d", word_count);
				end else begin
					code = $sscanf(line, "%h", value);
					if (code == 1)
						words.push_back(value);
				end
			end
		end
		$fclose(fd);
		if (word_count != words.size() || word_count % (BURST_LEN / 2) != 0
			|| word_count <= PART_WORDS) begin
			$display("The stimulus file holds %0d words but announces %0d", words.size(),
				word_count);
			report_failure();
		end
	endtask

	initial begin
		int wait_cnt;
		clk         = 1'b0;
		reset_d     = 1'b1;
		writes_en   = 1'b0;
		reads_en    = 1'b0;
		in_push     = 1'b0;
		in_data     = '0;
		out_pop     = 1'b0;
		rx_idx      = 0;
		cycle_cnt   = 0;
		lfsr        = 32'hc11;
		pop_random  = 1'b0;
		calib_seen  = 1'b0;
		load_words();
		cycle_limit = CALIB_CYCLES + RD_LATENCY + 40 * word_count + 200;
		repeat (4)
			step_cycle();
		reset_d = 1'b0;

		// Reset values and calibration
		check_flag(out_empty, 1'b1, "out_empty after reset");
		check_flag(in_full, 1'b0, "in_full after reset");
		check_flag(calib_done, 1'b0, "calib_done after reset");
		wait_cnt = 0;
		while (!calib_done && wait_cnt < CALIB_CYCLES + 2) begin
			step_cycle();
			wait_cnt++;
		end
		if (!calib_done) begin
			$display("calib_done did not rise within %0d cycles", CALIB_CYCLES + 2);
			report_failure();
		end
		calib_seen = 1'b1;

		// Less than one burst must stay in the input buffer
		writes_en = 1'b1;
		reads_en  = 1'b1;
		for (int i = 0; i < PART_WORDS; i++)
			push_word(words[i]);
		repeat (100) begin
			step_cycle();
			check_flag(out_empty, 1'b1, "out_empty with a partial burst");
		end

		// Round trip under random output back-pressure
		reads_en   = 1'b0;
		pop_random = 1'b1;
		for (int i = PART_WORDS; i < word_count; i++)
			push_word(words[i]);
		reads_en = 1'b1;
		while (rx_idx < word_count)
			step_cycle();

		// Drain
		reads_en = 1'b0;
		repeat (50) begin
			step_cycle();
			check_flag(out_empty, 1'b1, "out_empty after drain");
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/bridge_input.txt
# First data line: number of 64-bit words, a multiple of 16
# Then one 64-bit hex word per line, pushed and expected back in this order
16
0123456789abcdef
fedcba9876543210
00000000ffffffff
ffffffff00000000
a5a5a5a55a5a5a5a
1111111122222222
3333333344444444
deadbeefcafef00d
0000000000000001
8000000000000000
13579bdf2468ace0
0f0f0f0ff0f0f0f0
7fffffff80000001
0badc0de600dd00d
55aa55aaaa55aa55
c3c3c3c33c3c3c3c

// File: list.f
source/mem_bridge_pkg.sv
source/word_fifo.sv
source/burst_bridge.sv
source/port_mem_model.sv
source/bridge_top.sv
verif/bridge_checker.sv
verif/bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --assert --top-module bridge_tb -f list.f -o Vbridge_tb
./obj_dir/Vbridge_tb 2>&1 | tee sim.log
if grep -q "Done: errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
